// ==== Makefile ====
# Verilator build for the operand collector testbench
VERILATOR ?= verilator
TOP       ?= operand_collector_tb
FILELIST  ?= build.f
BUILD_DIR ?= obj_dir
JOBS      ?= 0
VFLAGS    ?= --binary --timing --timescale 1ns/1ps -j $(JOBS)

SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)

run: compile
	./$(SIM_BIN)

clean:
	rm -rf $(BUILD_DIR)

// ==== build.f ====
hdl/opc_pkg.sv
hdl/opc_dispatch.sv
hdl/opc_unit.sv
hdl/gpr_file.sv
hdl/opc_result_arb.sv
hdl/operand_collector.sv
verif/operand_collector_tb.sv

// ==== hdl/gpr_file.sv ====
// Single-bank register file, one read per cycle with 1-cycle latency; a write lands at the edge
`timescale 1ns/1ps

module gpr_file import opc_pkg::*; (
    input  logic                clk,
    input  logic                arst_n,
    input  logic [num_opcs-1:0] req_valid,
    input  gpr_req_t [num_opcs-1:0] req,
    output logic [num_opcs-1:0] req_ready,
    output logic [num_opcs-1:0] rsp_valid,
    output logic [xlen-1:0]     rsp_data,
    input  logic                wr_en,
    input  wb_t                 wr
);

    logic [xlen-1:0]      mem [num_warps][num_regs];
    logic [opc_sel_w-1:0] last_q;
    logic [opc_sel_w-1:0] pick;
    logic [num_opcs-1:0]  grant;
    logic [num_opcs-1:0]  rsp_valid_q;
    logic [xlen-1:0]      rd_data_q;
    gpr_req_t             sel_req;

    assign pick = rr_pick(req_valid, last_q);

    always_comb begin
        grant = '0;
        if (|req_valid) begin
            grant[pick] = 1'b1;
        end
    end

    assign req_ready = grant;
    assign sel_req   = req[pick];

    // The response is routed back only to the collector granted last cycle
    assign rsp_valid = rsp_valid_q;
    assign rsp_data  = rd_data_q;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            last_q      <= '0;
            rsp_valid_q <= '0;
        end else begin
            rsp_valid_q <= grant;
            if (|req_valid) begin
                last_q <= pick;
            end
        end
    end

    // Registers read zero after reset
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int w = 0; w < num_warps; w++) begin
                for (int r = 0; r < num_regs; r++) begin
                    mem[w][r] <= '0;
                end
            end
        end else if (wr_en) begin
            mem[wr.wid][wr.rd] <= wr.data;
        end
    end

    // A read granted at the same edge as a write still sees the old word
    always_ff @(posedge clk) begin
        if (|req_valid) begin
            rd_data_q <= mem[sel_req.wid][sel_req.idx];
        end
    end

endmodule

// ==== hdl/opc_dispatch.sv ====
// Steers one issue per cycle to the lowest free collector; the collector must latch it at the edge
`timescale 1ns/1ps

module opc_dispatch import opc_pkg::*; (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                issue_valid,
    input  issue_t              issue,
    output logic                issue_ready,
    input  logic [num_opcs-1:0] opc_free,
    output logic [num_opcs-1:0] opc_issue_valid,
    output issue_t              opc_issue
);

    logic [num_opcs-1:0] issued_q;
    logic [num_opcs-1:0] avail;
    logic [num_opcs-1:0] lowest;

    // A collector loaded at the last edge is never chosen again in the next cycle,
    // even if its free level has not dropped yet
    assign avail = opc_free & ~issued_q;

    // Isolate the lowest set bit, which is the priority pick
    assign lowest = avail & (~avail + num_opcs'(1));

    assign issue_ready     = |avail;
    assign opc_issue_valid = issue_valid ? lowest : '0;

    // All collectors see the same instruction, only the selected one captures it
    assign opc_issue = issue;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            issued_q <= '0;
        end else begin
            issued_q <= opc_issue_valid;
        end
    end

endmodule

// ==== hdl/opc_pkg.sv ====
// Sizes are fixed here for two collectors, 4 warps of 16 registers and a 32-bit single lane
package opc_pkg;

    localparam int num_opcs  = 2;
    localparam int num_regs  = 16;
    localparam int reg_idx_w = 4;
    localparam int num_warps = 4;
    localparam int wid_w     = 2;
    localparam int xlen      = 32;
    localparam int tag_w     = 4;
    localparam int opc_sel_w = 1;

    typedef struct packed {
        logic [wid_w-1:0]     wid;
        logic [reg_idx_w-1:0] rs1;
        logic [reg_idx_w-1:0] rs2;
        logic [reg_idx_w-1:0] rd;
        logic [tag_w-1:0]     tag;
    } issue_t;

    typedef struct packed {
        logic [wid_w-1:0]     wid;
        logic [reg_idx_w-1:0] rd;
        logic [xlen-1:0]      data;
    } wb_t;

    typedef struct packed {
        logic [wid_w-1:0]     wid;
        logic [reg_idx_w-1:0] idx;
    } gpr_req_t;

    typedef struct packed {
        logic [tag_w-1:0]     tag;
        logic [reg_idx_w-1:0] rd;
        logic [wid_w-1:0]     wid;
        logic [xlen-1:0]      rs1_data;
        logic [xlen-1:0]      rs2_data;
    } operands_t;

    // Round-robin pick, nearest requester after the last winner has priority
    function automatic logic [opc_sel_w-1:0] rr_pick(input logic [num_opcs-1:0] req,
                                                     input logic [opc_sel_w-1:0] last);
        logic [opc_sel_w-1:0] pick;
        int idx;
        pick = last;
        // Walk from the farthest to the nearest so the nearest match is kept
        for (int k = num_opcs; k >= 1; k--) begin
            idx = (int'(last) + k) % num_opcs;
            if (req[idx]) begin
                pick = opc_sel_w'(idx);
            end
        end
        return pick;
    endfunction

endpackage

// ==== hdl/opc_result_arb.sv ====
// Merges collector results round-robin into one output register held under back-pressure
`timescale 1ns/1ps

module opc_result_arb import opc_pkg::*; (
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic [num_opcs-1:0]  in_valid,
    input  operands_t [num_opcs-1:0] in_data,
    output logic [num_opcs-1:0]  in_ready,
    output logic                 out_valid,
    output operands_t            out,
    input  logic                 out_ready
);

    logic [opc_sel_w-1:0] last_q;
    logic [opc_sel_w-1:0] pick;
    logic                 load;
    logic                 out_valid_q;
    operands_t            out_q;

    assign pick = rr_pick(in_valid, last_q);

    // The register can take a new word when it is empty or drains this cycle
    assign load = !out_valid_q || out_ready;

    always_comb begin
        in_ready = '0;
        if (load && (|in_valid)) begin
            in_ready[pick] = 1'b1;
        end
    end

    assign out_valid = out_valid_q;
    assign out       = out_q;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            out_valid_q <= 1'b0;
            last_q      <= '0;
        end else if (load) begin
            out_valid_q <= |in_valid;
            if (|in_valid) begin
                last_q <= pick;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (load && (|in_valid)) begin
            out_q <= in_data[pick];
        end
    end

endmodule

// ==== hdl/opc_unit.sv ====
// One collector; reads rs1 then rs2 through the shared file and holds the result until taken
`timescale 1ns/1ps

module opc_unit import opc_pkg::*; (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                issue_valid,
    input  issue_t              issue,
    output logic                free,
    output logic                gpr_req_valid,
    output gpr_req_t            gpr_req,
    input  logic                gpr_req_ready,
    input  logic                gpr_rsp_valid,
    input  logic [xlen-1:0]     gpr_rsp_data,
    output logic [wid_w-1:0]    wid,
    output logic [num_regs-1:0] pending_regs,
    output logic                opc_valid,
    output operands_t           opc_data,
    input  logic                opc_ready
);

    typedef enum logic [1:0] {
        st_idle,
        st_rd1,
        st_rd2,
        st_done
    } state_t;

    state_t          state;
    issue_t          inst_q;
    logic [xlen-1:0] rs1_q;
    logic [xlen-1:0] rs2_q;
    logic            rd_busy_q;
    logic            rsp_slot_q;
    logic            granted;

    assign free          = (state == st_idle);
    assign gpr_req_valid = (state == st_rd1) || (state == st_rd2);
    assign gpr_req.wid   = inst_q.wid;
    assign gpr_req.idx   = (state == st_rd1) ? inst_q.rs1 : inst_q.rs2;
    assign granted       = gpr_req_valid && gpr_req_ready;

    // Result is offered only once the rs2 response has landed in its slot
    assign opc_valid = (state == st_done) && !rd_busy_q;
    assign opc_data  = '{tag: inst_q.tag, rd: inst_q.rd, wid: inst_q.wid,
                         rs1_data: rs1_q, rs2_data: rs2_q};

    assign wid = inst_q.wid;

    // A source stays pending until its read has been granted
    always_comb begin
        pending_regs = '0;
        if (state == st_rd1) begin
            pending_regs[inst_q.rs1] = 1'b1;
        end
        if ((state == st_rd1) || (state == st_rd2)) begin
            pending_regs[inst_q.rs2] = 1'b1;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state      <= st_idle;
            rd_busy_q  <= 1'b0;
            rsp_slot_q <= 1'b0;
        end else begin
            // A new grant can coincide with the previous response
            if (granted) begin
                rd_busy_q  <= 1'b1;
                rsp_slot_q <= (state == st_rd2);
            end else if (gpr_rsp_valid) begin
                rd_busy_q <= 1'b0;
            end
            case (state)
                st_idle: if (issue_valid) state <= st_rd1;
                st_rd1:  if (gpr_req_ready) state <= st_rd2;
                st_rd2:  if (gpr_req_ready) state <= st_done;
                st_done: if (opc_valid && opc_ready) state <= st_idle;
                default: state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (issue_valid && free) begin
            inst_q <= issue;
        end
        if (gpr_rsp_valid) begin
            if (rsp_slot_q) begin
                rs2_q <= gpr_rsp_data;
            end else begin
                rs1_q <= gpr_rsp_data;
            end
        end
    end

endmodule

// ==== hdl/operand_collector.sv ====
// Operand collection stage for two collectors; writebacks wait while a same-warp read is pending
`timescale 1ns/1ps

module operand_collector import opc_pkg::*; (
    input  logic      clk,
    input  logic      arst_n,
    input  logic      issue_valid,
    input  issue_t    issue,
    output logic      issue_ready,
    input  logic      wb_valid,
    input  wb_t       wb,
    output logic      wb_ready,
    output logic      out_valid,
    output operands_t out,
    input  logic      out_ready
);

    logic [num_opcs-1:0]                opc_free;
    logic [num_opcs-1:0]                opc_issue_valid;
    issue_t                             opc_issue;
    logic [num_opcs-1:0]                gpr_req_valid;
    gpr_req_t [num_opcs-1:0]            gpr_req;
    logic [num_opcs-1:0]                gpr_req_ready;
    logic [num_opcs-1:0]                gpr_rsp_valid;
    logic [xlen-1:0]                    gpr_rsp_data;
    logic [num_opcs-1:0][wid_w-1:0]     opc_wid;
    logic [num_opcs-1:0][num_regs-1:0]  opc_pending;
    logic [num_opcs-1:0]                opc_valid;
    operands_t [num_opcs-1:0]           opc_data;
    logic [num_opcs-1:0]                opc_ready;
    logic [num_regs-1:0]                war_pending;

    opc_dispatch dispatch (
        .clk             (clk),
        .arst_n          (arst_n),
        .issue_valid     (issue_valid),
        .issue           (issue),
        .issue_ready     (issue_ready),
        .opc_free        (opc_free),
        .opc_issue_valid (opc_issue_valid),
        .opc_issue       (opc_issue)
    );

    for (genvar i = 0; i < num_opcs; i++) begin : g_opc
        opc_unit unit (
            .clk           (clk),
            .arst_n        (arst_n),
            .issue_valid   (opc_issue_valid[i]),
            .issue         (opc_issue),
            .free          (opc_free[i]),
            .gpr_req_valid (gpr_req_valid[i]),
            .gpr_req       (gpr_req[i]),
            .gpr_req_ready (gpr_req_ready[i]),
            .gpr_rsp_valid (gpr_rsp_valid[i]),
            .gpr_rsp_data  (gpr_rsp_data),
            .wid           (opc_wid[i]),
            .pending_regs  (opc_pending[i]),
            .opc_valid     (opc_valid[i]),
            .opc_data      (opc_data[i]),
            .opc_ready     (opc_ready[i])
        );
    end

    // Unread sources of every collector working on the writeback's warp
    always_comb begin
        war_pending = '0;
        for (int i = 0; i < num_opcs; i++) begin
            if (opc_wid[i] == wb.wid) begin
                war_pending |= opc_pending[i];
            end
        end
    end

    assign wb_ready = !war_pending[wb.rd];

    gpr_file gpr (
        .clk       (clk),
        .arst_n    (arst_n),
        .req_valid (gpr_req_valid),
        .req       (gpr_req),
        .req_ready (gpr_req_ready),
        .rsp_valid (gpr_rsp_valid),
        .rsp_data  (gpr_rsp_data),
        .wr_en     (wb_valid && wb_ready),
        .wr        (wb)
    );

    opc_result_arb result_arb (
        .clk       (clk),
        .arst_n    (arst_n),
        .in_valid  (opc_valid),
        .in_data   (opc_data),
        .in_ready  (opc_ready),
        .out_valid (out_valid),
        .out       (out),
        .out_ready (out_ready)
    );

endmodule

// ==== verif/operand_collector_tb.sv ====
// Run from the project root so the golden file is found; each tag may be issued only once
`timescale 1ns/1ps

module operand_collector_tb import opc_pkg::*; ();

    localparam int max_cmds = 64;
    localparam int num_tags = 1 << tag_w;

    logic      clk;
    logic      arst_n;
    logic      issue_valid;
    issue_t    issue;
    logic      issue_ready;
    logic      wb_valid;
    wb_t       wb;
    logic      wb_ready;
    logic      out_valid;
    operands_t out;
    logic      out_ready;

    logic [71:0]          cmds [max_cmds];
    logic [xlen-1:0]      exp_rs1 [num_tags];
    logic [xlen-1:0]      exp_rs2 [num_tags];
    logic [reg_idx_w-1:0] exp_rd [num_tags];
    logic [wid_w-1:0]     exp_wid [num_tags];
    logic                 exp_valid [num_tags];
    int                   seen [num_tags];
    int                   num_cmds;
    int                   num_expected;
    int                   received;
    int                   cycles;
    int                   cycle_limit;
    logic                 holding;
    operands_t            held_out;

    operand_collector dut (
        .clk         (clk),
        .arst_n      (arst_n),
        .issue_valid (issue_valid),
        .issue       (issue),
        .issue_ready (issue_ready),
        .wb_valid    (wb_valid),
        .wb          (wb),
        .wb_ready    (wb_ready),
        .out_valid   (out_valid),
        .out         (out),
        .out_ready   (out_ready)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("TB FAILED");
        $fatal(1, "Run stopped after a failure");
    endtask

    task automatic check_value(input string name, input logic [79:0] actual,
                               input logic [79:0] expected);
        if (actual !== expected) begin
            $display("Fail at %0t: %s is %h, expected %h", $time, name, actual, expected);
            $display("TB FAILED");
            $fatal(1, "Value mismatch on %s", name);
        end
    endtask

    // Splits the golden words and fills the expected table by tag
    task automatic load_commands();
        logic [71:0] c;
        for (int i = 0; i < max_cmds; i++) begin
            cmds[i] = '0;
        end
        for (int t = 0; t < num_tags; t++) begin
            exp_valid[t] = 1'b0;
            seen[t]      = 0;
            exp_rs1[t]   = '0;
            exp_rs2[t]   = '0;
            exp_rd[t]    = '0;
            exp_wid[t]   = '0;
        end
        $readmemh("verif/operand_golden.txt", cmds);
        num_cmds     = 0;
        num_expected = 0;
        while ((num_cmds < max_cmds) && (cmds[num_cmds][71:68] != 4'h0)) begin
            c = cmds[num_cmds];
            if (c[71:68] == 4'h2) begin
                exp_wid[c[3:0]] = c[65:64];
                exp_rd[c[3:0]]  = c[7:4];
            end else if (c[71:68] == 4'h3) begin
                exp_valid[c[67:64]] = 1'b1;
                exp_rs1[c[67:64]]   = c[63:32];
                exp_rs2[c[67:64]]   = c[31:0];
                num_expected++;
            end
            num_cmds++;
        end
        if (num_cmds == 0) begin
            report_failure("The golden file holds no commands");
        end
    endtask

    task automatic send_write(input logic [71:0] c);
        wb.wid   = c[65:64];
        wb.rd    = c[35:32];
        wb.data  = c[31:0];
        wb_valid = 1'b1;
        @(negedge clk);
        // A flagged write targets a register still unread by a collector
        if (c[36]) begin
            check_value("wb_ready", 80'(wb_ready), 80'(1'b0));
        end
        while (!wb_ready) @(negedge clk);
        @(posedge clk);
        #2;
        wb_valid = 1'b0;
    endtask

    task automatic send_issue(input logic [71:0] c);
        issue.wid   = c[65:64];
        issue.rs1   = c[15:12];
        issue.rs2   = c[11:8];
        issue.rd    = c[7:4];
        issue.tag   = c[3:0];
        issue_valid = 1'b1;
        @(negedge clk);
        while (!issue_ready) @(negedge clk);
        @(posedge clk);
        #2;
        issue_valid = 1'b0;
    endtask

    task automatic record_output(input operands_t o);
        if (!exp_valid[o.tag]) begin
            report_failure($sformatf("A result arrived with unexpected tag %0d", o.tag));
        end
        if (seen[o.tag] != 0) begin
            report_failure($sformatf("The result for tag %0d arrived twice", o.tag));
        end
        check_value("out.rs1_data", 80'(o.rs1_data), 80'(exp_rs1[o.tag]));
        check_value("out.rs2_data", 80'(o.rs2_data), 80'(exp_rs2[o.tag]));
        check_value("out.rd", 80'(o.rd), 80'(exp_rd[o.tag]));
        check_value("out.wid", 80'(o.wid), 80'(exp_wid[o.tag]));
        seen[o.tag]++;
        received++;
    endtask

    // Outputs are sampled at the falling edge, between drive and transfer
    always @(negedge clk) begin
        if (arst_n && out_valid) begin
            if (holding) begin
                check_value("out", 80'(out), 80'(held_out));
            end
            if (out_ready) begin
                record_output(out);
                holding = 1'b0;
            end else begin
                holding  = 1'b1;
                held_out = out;
            end
        end else if (holding) begin
            report_failure("out_valid dropped before its result was taken");
        end
    end

    // Back-pressure: roughly one cycle in three stalls the output
    always @(posedge clk) begin
        #2;
        if (arst_n) begin
            out_ready = ($urandom % 32'd3) != 32'd0;
        end
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("TB FAILED");
            $fatal(1, "Timeout after %0d cycles waiting for the DUT", cycles);
        end
    end

    initial begin
        void'($urandom(15));
        arst_n      = 1'b0;
        issue_valid = 1'b0;
        issue       = '0;
        wb_valid    = 1'b0;
        wb          = '0;
        out_ready   = 1'b0;
        holding     = 1'b0;
        received    = 0;
        cycles      = 0;
        cycle_limit = 1000;
        load_commands();
        cycle_limit = 40 * num_cmds;
        repeat (4) @(posedge clk);
        #2;
        arst_n = 1'b1;
        @(negedge clk);
        check_value("out_valid", 80'(out_valid), 80'(1'b0));
        check_value("issue_ready", 80'(issue_ready), 80'(1'b1));
        check_value("wb_ready", 80'(wb_ready), 80'(1'b1));
        @(posedge clk);
        #2;
        for (int i = 0; i < num_cmds; i++) begin
            if (cmds[i][71:68] == 4'h1) begin
                send_write(cmds[i]);
            end else if (cmds[i][71:68] == 4'h2) begin
                send_issue(cmds[i]);
            end
        end
        // Every counted result is a distinct expected tag, so reaching the count means all arrived
        while (received < num_expected) @(negedge clk);
        // Extra cycles let a duplicated result show up
        repeat (8) @(negedge clk);
        $display("TB PASSED");
        $finish;
    end

endmodule

// ==== verif/operand_golden.txt ====
// Word = kind, a, b, c. Kind 1 write: a wid, b stall flag and rd, c data
// Kind 2 issue: a wid, c rs1 rs2 rd tag. Kind 3 expect: a tag, b rs1 data, c rs2 data
2_3_00000000_00005670
3_0_00000000_00000000
1_0_00000001_11111111
1_0_00000002_22222222
1_1_00000001_a5a5a5a5
2_0_00000000_00001231
3_1_11111111_22222222
2_2_00000000_00001232
3_2_00000000_00000000
2_1_00000000_00001233
3_3_a5a5a5a5_00000000
2_0_00000000_00004154
3_4_00000000_11111111
1_0_00000014_deadbeef
2_0_00000000_00004465
3_5_deadbeef_deadbeef
2_3_00000000_00005176
3_6_00000000_00000000
1_3_00000005_0badf00d
2_3_00000000_00005687
3_7_0badf00d_00000000
